// File: hw/cache_response_defs.svh
/* Cache response field widths and FIFO sizing
   Shared by the response package and the FIFO side modules */

`ifndef CACHE_RESPONSE_DEFS_SVH
`define CACHE_RESPONSE_DEFS_SVH

// --------------------
// Source route fields
// --------------------
`define CR_ID_CU_W      4
`define CR_ID_BUNDLE_W  4
`define CR_ID_LANE_W    4
`define CR_ID_ENGINE_W  4

// Address and data
`define CR_ADDR_W       32
`define CR_DATA_W       32

// --------------------
// Response FIFO sizing
// --------------------
// Depth kept a power of two, pointers wrap on their own
`define CR_FIFO_DEPTH       32
// Half depth plus three
`define CR_PROG_THRESH      19
// Cycles the FIFO reports reset busy
`define CR_RST_BUSY_CYCLES  8

`endif

// File: hw/cache_response_pkg.sv
/* Cache response types
   Route, payload, packet and FIFO status structs plus the response mapping */

`include "cache_response_defs.svh"

package cache_response_pkg;

  // --------------------
  // Routing and meta
  // --------------------
  // Source route, 16 bits
  typedef struct packed {
    logic [`CR_ID_CU_W-1:0]     id_cu;
    logic [`CR_ID_BUNDLE_W-1:0] id_bundle;
    logic [`CR_ID_LANE_W-1:0]   id_lane;
    logic [`CR_ID_ENGINE_W-1:0] id_engine;
  } packet_source_t;

  // Response opcodes
  typedef enum logic [1:0] {
    CMD_READ  = 2'd0,
    CMD_WRITE = 2'd1,
    CMD_FLUSH = 2'd2
  } cache_cmd_t;

  // Route, opcode and address, 50 bits
  typedef struct packed {
    packet_source_t         packet_source;
    cache_cmd_t             cmd;
    logic [`CR_ADDR_W-1:0]  address;
  } cache_meta_t;

  // --------------------
  // Payloads and packets
  // --------------------
  // Cache side, 83 bits
  typedef struct packed {
    logic                   iob;
    cache_meta_t            meta;
    logic [`CR_DATA_W-1:0]  data;
  } cache_response_payload_t;

  typedef struct packed {
    logic                    valid;
    cache_response_payload_t payload;
  } cache_response_t;

  // Memory side, iob dropped, 82 bits
  typedef struct packed {
    cache_meta_t            meta;
    logic [`CR_DATA_W-1:0]  data;
  } memory_payload_t;

  typedef struct packed {
    logic            valid;
    memory_payload_t payload;
  } memory_packet_t;

  // --------------------
  // FIFO control and status
  // --------------------
  typedef struct packed {
    logic rd_en;
  } fifo_signals_in_t;

  typedef struct packed {
    logic full;
    logic empty;
    logic valid;
    logic prog_full;
    logic wr_rst_busy;
    logic rd_rst_busy;
  } fifo_signals_out_t;

  // Setup sequencing after reset
  typedef enum logic [1:0] {
    ST_RESET = 2'd0,
    ST_FLUSH = 2'd1,
    ST_READY = 2'd2
  } setup_state_t;

  // Meta and data carried over, iob only matters on the cache side
  function automatic memory_payload_t map_response_to_memory(
    input cache_response_payload_t rsp
  );
    memory_payload_t pkt;
    pkt.meta = rsp.meta;
    pkt.data = rsp.data;
    return pkt;
  endfunction

endpackage

// File: hw/response_fifo_sync.sv
/* Response FIFO
   Synchronous circular buffer with registered first word, occupancy
   flags and reset-busy indication */

`timescale 1ns/1ps
`include "cache_response_defs.svh"

module response_fifo_sync (
  input  logic                                        ap_clk,
  input  logic                                        clear,
  input  logic                                        busy,
  input  cache_response_pkg::cache_response_payload_t din,
  input  logic                                        wr_en,
  input  logic                                        rd_en,
  output cache_response_pkg::cache_response_payload_t dout,
  output cache_response_pkg::fifo_signals_out_t       status
);
  import cache_response_pkg::*;

  localparam int DEPTH = `CR_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  // One extra bit so a full buffer is countable
  localparam int CW    = $clog2(DEPTH + 1);

  cache_response_payload_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          wr_fire;
  logic          valid_q;

  // --------------------
  // Flags
  // --------------------
  assign full    = (count == CW'(DEPTH));
  // Drop writes while full or during the busy window
  assign wr_fire = wr_en & ~busy & ~full;

  // --------------------
  // Pointers and occupancy
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (clear) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Read is already qualified with not empty upstream
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Valid follows the pop by one cycle
      valid_q <= rd_en;
    end
  end

  // Storage, no reset
  always_ff @(posedge ap_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= din;
    end
  end

  // Registered read word
  always_ff @(posedge ap_clk) begin
    if (rd_en) begin
      dout <= mem[rd_ptr];
    end
  end

  // --------------------
  // Status out
  // --------------------
  assign status.full        = full;
  assign status.empty       = (count == '0);
  assign status.valid       = valid_q;
  assign status.prog_full   = (count >= CW'(`CR_PROG_THRESH));
  // Both busy flags share the setup window
  assign status.wr_rst_busy = busy;
  assign status.rd_rst_busy = busy;

endmodule

// File: hw/fifo_reset_timer.sv
/* FIFO reset-busy timer
   Counts down the busy window after start and pulses done at zero */

`timescale 1ns/1ps
`include "cache_response_defs.svh"

module fifo_reset_timer (
  input  logic ap_clk,
  input  logic rst,
  input  logic start,
  output logic done
);

  localparam int CNT_W = $clog2(`CR_RST_BUSY_CYCLES + 1);

  logic [CNT_W-1:0] count;
  logic             running;

  // --------------------
  // Down-counter
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      count   <= '0;
      running <= 1'b0;
      done    <= 1'b0;
    end else begin
      // Single cycle pulse by default low
      done <= 1'b0;
      if (start) begin
        count   <= CNT_W'(`CR_RST_BUSY_CYCLES);
        running <= 1'b1;
      end else if (running) begin
        count <= count - 1'b1;
        // Last step reaches zero
        if (count == CNT_W'(1)) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/response_setup_fsm.sv
/* Response setup FSM
   Sequences FIFO clear, the busy window and the setup level after reset */

`timescale 1ns/1ps

module response_setup_fsm (
  input  logic ap_clk,
  input  logic rst,
  input  logic timer_done,
  output logic timer_start,
  output logic fifo_clear,
  output logic busy,
  output logic setup
);
  import cache_response_pkg::*;

  setup_state_t state;
  setup_state_t state_next;

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      state <= ST_RESET;
    end else begin
      state <= state_next;
    end
  end

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      // One cycle to clear and arm the timer
      ST_RESET: state_next = ST_FLUSH;
      // Hold until the busy window ends
      ST_FLUSH: begin
        if (timer_done) begin
          state_next = ST_READY;
        end
      end
      ST_READY: state_next = ST_READY;
      default:  state_next = ST_RESET;
    endcase
  end

  // --------------------
  // Moore outputs
  // --------------------
  assign fifo_clear  = (state == ST_RESET);
  assign timer_start = (state == ST_RESET);
  assign busy        = (state == ST_FLUSH);
  // Setup visible until ready
  assign setup       = (state != ST_READY);

endmodule

// File: hw/response_route_demux.sv
/* Response route demux
   Maps popped responses to memory packets and steers them to the
   setup CU port and the CU bundles port by source route */

`timescale 1ns/1ps

module response_route_demux (
  input  logic                                        ap_clk,
  input  logic                                        rst,
  input  logic                                        din_valid,
  input  cache_response_pkg::cache_response_payload_t din,
  output cache_response_pkg::memory_packet_t          out_0,
  output cache_response_pkg::memory_packet_t          out_1
);
  import cache_response_pkg::*;

  memory_payload_t mapped;
  packet_source_t  src;
  logic            to_setup;
  logic            to_bundles;

  // --------------------
  // Mapping and filters
  // --------------------
  assign mapped = map_response_to_memory(din);
  assign src    = din.meta.packet_source;

  // Setup CU owns all-zero routes, all ones is broadcast
  assign to_setup   = (&src) | ~(|src);
  // Bundles take any nonzero route
  assign to_bundles = |src;

  // --------------------
  // Output registers
  // --------------------
  always_ff @(posedge ap_clk) begin
    // Payload copy to both ports, valid decides who takes it
    out_0.payload <= mapped;
    out_1.payload <= mapped;
    if (rst) begin
      out_0.valid <= 1'b0;
      out_1.valid <= 1'b0;
    end else begin
      out_0.valid <= din_valid & to_setup;
      out_1.valid <= din_valid & to_bundles;
    end
  end

endmodule

// File: hw/cache_generator_response.sv
/* Cache generator response side
   Queues cache responses, pops them on consumer read-enable and routes
   memory packets to the setup CU and the CU bundles */

`timescale 1ns/1ps

module cache_generator_response (
  input  logic                                  ap_clk,
  input  logic                                  areset_control,
  input  cache_response_pkg::cache_response_t   response_in,
  input  cache_response_pkg::fifo_signals_in_t  fifo_response_signals_in,
  output cache_response_pkg::fifo_signals_out_t fifo_response_signals_out,
  output cache_response_pkg::memory_packet_t    response_out_0,
  output cache_response_pkg::memory_packet_t    response_out_1,
  output logic                                  fifo_setup_signal
);
  import cache_response_pkg::*;

  // Reset branches
  logic rst_control;
  logic rst_fifo;
  logic rst_demux;

  cache_response_t         response_in_reg;
  fifo_signals_in_t        signals_in_reg;
  cache_response_payload_t fifo_dout;
  fifo_signals_out_t       fifo_status;

  logic fifo_pop;
  logic fifo_clear;
  logic fifo_busy;
  logic timer_start;
  logic timer_done;
  logic setup_int;

  // --------------------
  // Reset fan-out
  // --------------------
  always_ff @(posedge ap_clk) begin
    rst_control <= areset_control;
    rst_fifo    <= areset_control;
    rst_demux   <= areset_control;
  end

  // --------------------
  // Input registers
  // --------------------
  always_ff @(posedge ap_clk) begin
    response_in_reg.payload <= response_in.payload;
    if (rst_control) begin
      response_in_reg.valid <= 1'b0;
      signals_in_reg.rd_en  <= 1'b0;
    end else begin
      response_in_reg.valid <= response_in.valid;
      signals_in_reg.rd_en  <= fifo_response_signals_in.rd_en;
    end
  end

  // Pop only while data is held
  assign fifo_pop = signals_in_reg.rd_en & ~fifo_status.empty;

  // --------------------
  // Output registers
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (rst_control) begin
      fifo_setup_signal <= 1'b1;
    end else begin
      fifo_setup_signal <= setup_int;
    end
  end

  // Status seen by the consumer one cycle late
  always_ff @(posedge ap_clk) begin
    fifo_response_signals_out <= fifo_status;
  end

  // --------------------
  // Setup sequencing on the FIFO reset branch
  // --------------------
  response_setup_fsm u_setup_fsm (
    .ap_clk      (ap_clk),
    .rst         (rst_fifo),
    .timer_done  (timer_done),
    .timer_start (timer_start),
    .fifo_clear  (fifo_clear),
    .busy        (fifo_busy),
    .setup       (setup_int)
  );

  fifo_reset_timer u_reset_timer (
    .ap_clk (ap_clk),
    .rst    (rst_fifo),
    .start  (timer_start),
    .done   (timer_done)
  );

  // Response queue
  response_fifo_sync u_response_fifo (
    .ap_clk (ap_clk),
    .clear  (fifo_clear),
    .busy   (fifo_busy),
    .din    (response_in_reg.payload),
    .wr_en  (response_in_reg.valid),
    .rd_en  (fifo_pop),
    .dout   (fifo_dout),
    .status (fifo_status)
  );

  // Requestor steering
  response_route_demux u_route_demux (
    .ap_clk    (ap_clk),
    .rst       (rst_demux),
    .din_valid (fifo_status.valid),
    .din       (fifo_dout),
    .out_0     (response_out_0),
    .out_1     (response_out_1)
  );

endmodule

// File: sim/cache_generator_response_tb.sv
/* Cache generator response testbench
   Trace driven pushes, pops and status checks with a per-port scoreboard */

`timescale 1ns/1ps
`include "cache_response_defs.svh"

module cache_generator_response_tb;
  import cache_response_pkg::*;

  localparam int MAX_REC = 64;

  logic              ap_clk;
  logic              areset_control;
  cache_response_t   response_in;
  fifo_signals_in_t  fifo_response_signals_in;
  fifo_signals_out_t fifo_response_signals_out;
  memory_packet_t    response_out_0;
  memory_packet_t    response_out_1;
  logic              fifo_setup_signal;

  // --------------------
  // Trace records
  // --------------------
  byte          rec_op    [MAX_REC];
  logic [15:0]  rec_route [MAX_REC];
  logic [1:0]   rec_cmd   [MAX_REC];
  logic [31:0]  rec_addr  [MAX_REC];
  logic [31:0]  rec_data  [MAX_REC];
  logic         rec_iob   [MAX_REC];
  logic [2:0]   rec_mask  [MAX_REC];
  int           rec_count [MAX_REC];
  int           num_rec = 0;

  // One scoreboard queue per requestor port
  memory_payload_t exp_q0[$];
  memory_payload_t exp_q1[$];

  int   mismatch_count = 0;
  int   other_count    = 0;
  int   cycle_count    = 0;
  int   cycle_limit    = 200;
  // Entries the FIFO should hold right now
  int   model_occ      = 0;
  logic checking       = 1'b0;

  cache_generator_response dut0 (
    .ap_clk                    (ap_clk),
    .areset_control            (areset_control),
    .response_in               (response_in),
    .fifo_response_signals_in  (fifo_response_signals_in),
    .fifo_response_signals_out (fifo_response_signals_out),
    .response_out_0            (response_out_0),
    .response_out_1            (response_out_1),
    .fifo_setup_signal         (fifo_setup_signal)
  );

  initial ap_clk = 1'b0;
  always #10 ap_clk = ~ap_clk;

  // Run limit from the trace length
  always @(posedge ap_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Drive point just after the rising edge
  task automatic next_cycle();
    @(posedge ap_clk);
    #1;
  endtask

  // --------------------
  // Typed compares
  // --------------------
  task automatic compare_packet(input memory_packet_t got, input memory_packet_t exp,
                                input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_status(input fifo_signals_out_t got, input fifo_signals_out_t exp,
                                input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s got %b expected %b (full empty valid pf wrb rdb)",
               $time, what, got, exp);
    end
  endtask

  task automatic compare_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Pops the port's queue when a packet shows up
  task automatic check_port(input int port, input memory_packet_t got);
    memory_packet_t exp;
    int             depth;
    depth = (port == 0) ? exp_q0.size() : exp_q1.size();
    if (got.valid === 1'b1) begin
      if (depth == 0) begin
        other_count++;
        $display("packet on port %0d at %0t ns with nothing expected", port, $time);
      end else begin
        exp.valid = 1'b1;
        if (port == 0) begin
          exp.payload = exp_q0.pop_front();
        end else begin
          exp.payload = exp_q1.pop_front();
        end
        compare_packet(got, exp, $sformatf("port %0d packet", port));
      end
    end
  endtask

  // Outputs settle by the falling edge
  always @(negedge ap_clk) begin
    if (checking) begin
      check_port(0, response_out_0);
      check_port(1, response_out_1);
    end
  end

  // --------------------
  // Trace handling
  // --------------------
  task automatic read_trace();
    int          fd;
    int          code;
    string       line;
    byte         op;
    logic [15:0] route;
    logic [1:0]  cmd;
    logic [31:0] addr;
    logic [31:0] data;
    logic        iob;
    logic [2:0]  mask;
    int          count;
    fd = $fopen("sim/response_trace.txt", "r");
    if (fd == 0) begin
      other_count++;
      $display("could not open the trace file sim/response_trace.txt");
      return;
    end
    while (!$feof(fd) && num_rec < MAX_REC) begin
      code = $fgets(line, fd);
      // Skip comments and blank lines
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%c %h %h %h %h %h %h %d",
                       op, route, cmd, addr, data, iob, mask, count);
        if (code == 8) begin
          rec_op[num_rec]    = op;
          rec_route[num_rec] = route;
          rec_cmd[num_rec]   = cmd;
          rec_addr[num_rec]  = addr;
          rec_data[num_rec]  = data;
          rec_iob[num_rec]   = iob;
          rec_mask[num_rec]  = mask;
          rec_count[num_rec] = count;
          num_rec++;
        end else begin
          other_count++;
          $display("trace line could not be parsed: %s", line);
        end
      end
    end
    $fclose(fd);
  endtask

  // W record pushes responses with address and data stepping by one
  task automatic push_record(input int idx);
    cache_response_payload_t p;
    memory_payload_t         m;
    int                      i;
    for (i = 0; i < rec_count[idx]; i++) begin
      p.iob                = rec_iob[idx];
      p.meta.packet_source = rec_route[idx];
      p.meta.cmd           = cache_cmd_t'(rec_cmd[idx]);
      p.meta.address       = rec_addr[idx] + i;
      p.data               = rec_data[idx] + i;
      // Expected packet without iob
      m.meta.packet_source = rec_route[idx];
      m.meta.cmd           = cache_cmd_t'(rec_cmd[idx]);
      m.meta.address       = rec_addr[idx] + i;
      m.data               = rec_data[idx] + i;
      // Full FIFO drops the write
      if (model_occ < `CR_FIFO_DEPTH) begin
        if (rec_mask[idx][0]) begin
          exp_q0.push_back(m);
        end
        if (rec_mask[idx][1]) begin
          exp_q1.push_back(m);
        end
        model_occ++;
      end
      response_in.valid   = 1'b1;
      response_in.payload = p;
      next_cycle();
    end
    response_in.valid = 1'b0;
  endtask

  // P record holds rd_en for one pop per cycle while data is held
  task automatic pop_record(input int idx);
    fifo_response_signals_in.rd_en = 1'b1;
    repeat (rec_count[idx]) next_cycle();
    fifo_response_signals_in.rd_en = 1'b0;
    model_occ = (rec_count[idx] >= model_occ) ? 0 : model_occ - rec_count[idx];
    // Pipeline drains
    repeat (4) next_cycle();
  endtask

  // S record takes its flags from the mask column
  task automatic status_record(input int idx);
    fifo_signals_out_t exp;
    exp           = '0;
    exp.full      = rec_mask[idx][2];
    exp.empty     = rec_mask[idx][1];
    exp.prog_full = rec_mask[idx][0];
    repeat (4) next_cycle();
    @(negedge ap_clk);
    compare_status(fifo_response_signals_out, exp, $sformatf("status at record %0d", idx));
    next_cycle();
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    fifo_signals_out_t exp_reset;
    int                r;
    areset_control                 = 1'b1;
    response_in                    = '0;
    fifo_response_signals_in.rd_en = 1'b0;
    read_trace();
    cycle_limit = 20 * num_rec + 200;

    repeat (2) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;

    // Busy window open and nothing queued
    repeat (3) @(posedge ap_clk);
    @(negedge ap_clk);
    exp_reset             = '0;
    exp_reset.empty       = 1'b1;
    exp_reset.wr_rst_busy = 1'b1;
    exp_reset.rd_rst_busy = 1'b1;
    compare_status(fifo_response_signals_out, exp_reset, "status after reset");
    compare_level(fifo_setup_signal, 1'b1, "fifo_setup_signal after reset");
    compare_level(response_out_0.valid, 1'b0, "port 0 valid after reset");
    compare_level(response_out_1.valid, 1'b0, "port 1 valid after reset");
    checking = 1'b1;

    // Setup window end
    while (fifo_setup_signal !== 1'b0) begin
      @(negedge ap_clk);
    end
    next_cycle();

    for (r = 0; r < num_rec; r++) begin
      case (rec_op[r])
        "W":     push_record(r);
        "P":     pop_record(r);
        "S":     status_record(r);
        default: begin
          other_count++;
          $display("unknown trace opcode at record %0d", r);
        end
      endcase
    end

    repeat (6) next_cycle();
    if (exp_q0.size() != 0) begin
      other_count++;
      $display("%0d expected packets never arrived on port 0", exp_q0.size());
    end
    if (exp_q1.size() != 0) begin
      other_count++;
      $display("%0d expected packets never arrived on port 1", exp_q1.size());
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+hw
hw/cache_response_pkg.sv
hw/response_fifo_sync.sv
hw/fifo_reset_timer.sv
hw/response_setup_fsm.sv
hw/response_route_demux.sv
hw/cache_generator_response.sv
sim/cache_generator_response_tb.sv

// File: sim/response_trace.txt
# op route cmd addr data iob mask count; all hex except count, which is decimal
# W pushes count responses with addr and data stepping by one, mask bit0 port 0, bit1 port 1
# P holds rd_en for count cycles; S checks status, mask bit2 full, bit1 empty, bit0 prog_full
# Routing, one response per route class
W 0000 0 00001000 a0000001 1 1 1
W 1234 1 00001004 a0000002 0 2 1
W ffff 2 00001008 a0000003 1 3 1
W 0001 0 0000100c a0000004 0 2 1
W 0000 1 00001010 a0000005 0 1 1
S 0000 0 00000000 00000000 0 0 0
# Drain with extra empty cycles
P 0000 0 00000000 00000000 0 0 8
S 0000 0 00000000 00000000 0 2 0
# Fill below the programmable threshold
W 0100 1 00002000 b0000000 0 2 18
S 0000 0 00000000 00000000 0 0 0
W 0000 0 00002100 b0000100 1 1 1
S 0000 0 00000000 00000000 0 1 0
# Fill to depth, then pushes that are dropped
W ffff 2 00003000 c0000000 1 3 13
S 0000 0 00000000 00000000 0 5 0
W 0020 1 00004000 d0000000 0 2 3
S 0000 0 00000000 00000000 0 5 0
P 0000 0 00000000 00000000 0 0 40
S 0000 0 00000000 00000000 0 2 0
# Short burst after the full drain
W 00f0 0 00005000 e0000000 1 2 2
W 0000 2 00005100 e0000100 0 1 1
P 0000 0 00000000 00000000 0 0 5
S 0000 0 00000000 00000000 0 2 0
